// ==== design/isaDefs.sv ====
package isaDefs;

	localparam int wordWidth = 32; // XLEN for RV32I
	localparam int registerCount = 32; // x0 through x31
	localparam int memoryWords = 1024; // Unified instruction and data memory depth

	// Major opcodes (bits 6:0), RV32I base set only
	typedef enum logic [6:0]
	{
		LOAD = 7'b0000011,
		STORE = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL = 7'b1101111,
		JALR = 7'b1100111,
		LUI = 7'b0110111,
		AUIPC = 7'b0010111,
		OP_IMM = 7'b0010011,
		OP = 7'b0110011,
		MISC_MEM = 7'b0001111, // fence, treated as nop
		SYSTEM = 7'b1110011 // ecall/ebreak
	} Opcode_t;

	// Field split of a 32-bit instruction, R-type layout
	// Other formats pull their immediates from the raw bits
	typedef struct packed
	{
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		Opcode_t opcode;
	} Instruction_t;

endpackage

// ==== design/controlDefs.sv ====
package controlDefs;

	// Control FSM states, one-hot
	typedef enum logic [3:0]
	{
		INITIAL_FETCH = 4'b0001,
		FETCH_EXECUTE = 4'b0010,
		EXECUTE = 4'b0100,
		HALT = 4'b1000
	} State_t;

	typedef enum logic [1:0]
	{
		NOP,
		LOAD,
		STORE_PRELOAD, // Read old word ahead of a sub-word store
		STORE
	} MemoryMode_t;

	typedef enum logic [2:0] {I, S, B, U, J, LUI, AUIPC} ImmediateFormerMode_t;

	typedef enum logic [1:0] {INCREMENT, JAL, JALR, BRANCH} BranchALUMode_t;

	typedef enum logic {CURRENT_PC, NEXT_PC} InstructionAddressSource_t;

	// One-hot rd source enables
	typedef struct packed
	{
		logic memoryOutputEnable;
		logic aluOutputEnable;
		logic immediateFormerOutputEnable;
		logic branchALUOutputEnable;
	} RDSourceSelectLines_t;

	typedef enum logic [2:0] {NONE, STOP, CONTROL_ERROR, PC_MISALIGNED, MEMORY_ERROR} HaltCause_t;

	typedef struct packed
	{
		logic rdWriteEnable;
		MemoryMode_t memoryMode;
		RDSourceSelectLines_t rdSourceSelectLines;
		logic programCounterWriteEnable;
		InstructionAddressSource_t instructionAddressSource;
		logic opImm;
		ImmediateFormerMode_t immediateFormerMode;
		BranchALUMode_t branchALUMode;
	} ControlLines_t;

endpackage

// ==== design/immediateFormer.sv ====
`timescale 1ns/100ps

module immediateFormer
(
	input isaDefs::Instruction_t instruction,
	input logic [isaDefs::wordWidth-1:0] pc,
	input controlDefs::ImmediateFormerMode_t immediateFormerMode,
	output logic [isaDefs::wordWidth-1:0] immediate,
	output logic [isaDefs::wordWidth-1:0] immediateResult
);
	import isaDefs::*;
	import controlDefs::*;

	logic [wordWidth-1:0] bits;
	logic [wordWidth-1:0] upperImmediate;

	assign bits = instruction; // Raw word for scattered immediate fields
	assign upperImmediate = {bits[31:12], 12'b0};

	always_comb
	begin
		unique case (immediateFormerMode)
			I: immediate = {{20{bits[31]}}, bits[31:20]};
			S: immediate = {{20{bits[31]}}, bits[31:25], bits[11:7]};
			B: immediate = {{19{bits[31]}}, bits[31], bits[7], bits[30:25], bits[11:8], 1'b0};
			J: immediate = {{11{bits[31]}}, bits[31], bits[19:12], bits[20], bits[30:21], 1'b0};
			default: immediate = upperImmediate; // U, LUI, AUIPC
		endcase
	end

	// rd value for lui/auipc
	assign immediateResult = (immediateFormerMode == controlDefs::AUIPC) ?
		pc + upperImmediate : immediate;

endmodule

// ==== design/executeUnit.sv ====
`timescale 1ns/100ps

module executeUnit
(
	input isaDefs::Instruction_t instruction,
	input logic [isaDefs::wordWidth-1:0] pc,
	input logic [isaDefs::wordWidth-1:0] rs1Value,
	input logic [isaDefs::wordWidth-1:0] rs2Value,
	input logic [isaDefs::wordWidth-1:0] immediate,
	input logic opImm,
	input controlDefs::BranchALUMode_t branchALUMode,
	output logic [isaDefs::wordWidth-1:0] aluResult,
	output logic [isaDefs::wordWidth-1:0] nextPc,
	output logic [isaDefs::wordWidth-1:0] linkValue
);
	import isaDefs::*;
	import controlDefs::*;

	logic [wordWidth-1:0] operandB;
	logic [4:0] shiftAmount;
	logic isMemoryAccess;
	logic takeBranch;

	assign operandB = opImm ? immediate : rs2Value;
	assign shiftAmount = operandB[4:0];
	assign isMemoryAccess = (instruction.opcode == isaDefs::LOAD) ||
		(instruction.opcode == isaDefs::STORE);

	always_comb
	begin
		if (isMemoryAccess)
			aluResult = rs1Value + immediate; // Effective address
		else
		begin
			unique case (instruction.funct3)
				3'b000: aluResult = (!opImm && instruction.funct7[5]) ?
					rs1Value - operandB : rs1Value + operandB; // No subi
				3'b001: aluResult = rs1Value << shiftAmount;
				3'b010: aluResult = {31'b0, $signed(rs1Value) < $signed(operandB)};
				3'b011: aluResult = {31'b0, rs1Value < operandB};
				3'b100: aluResult = rs1Value ^ operandB;
				3'b101: aluResult = instruction.funct7[5] ? // srai keeps this bit in imm
					$unsigned($signed(rs1Value) >>> shiftAmount) : rs1Value >> shiftAmount;
				3'b110: aluResult = rs1Value | operandB;
				default: aluResult = rs1Value & operandB;
			endcase
		end
	end

	// Branch condition
	always_comb
	begin
		unique case (instruction.funct3)
			3'b000: takeBranch = (rs1Value == rs2Value); // beq
			3'b001: takeBranch = (rs1Value != rs2Value); // bne
			3'b100: takeBranch = $signed(rs1Value) < $signed(rs2Value);
			3'b101: takeBranch = $signed(rs1Value) >= $signed(rs2Value);
			3'b110: takeBranch = rs1Value < rs2Value; // bltu
			3'b111: takeBranch = rs1Value >= rs2Value; // bgeu
			default: takeBranch = 1'b0; // 010/011 undefined, fall through
		endcase
	end

	assign linkValue = pc + 32'd4;

	always_comb
	begin
		unique case (branchALUMode)
			controlDefs::JAL: nextPc = pc + immediate;
			controlDefs::JALR: nextPc = (rs1Value + immediate) & ~32'd1; // Low bit dropped
			controlDefs::BRANCH: nextPc = takeBranch ? pc + immediate : linkValue;
			default: nextPc = linkValue;
		endcase
	end

endmodule

// ==== design/resultWriter.sv ====
`timescale 1ns/100ps

module resultWriter
(
	input logic clock,
	input isaDefs::Instruction_t instruction,
	input logic rdWriteEnable,
	input controlDefs::RDSourceSelectLines_t rdSourceSelectLines,
	input logic [isaDefs::wordWidth-1:0] loadValue,
	input logic [isaDefs::wordWidth-1:0] aluResult,
	input logic [isaDefs::wordWidth-1:0] immediateResult,
	input logic [isaDefs::wordWidth-1:0] linkValue,
	output logic [isaDefs::wordWidth-1:0] rs1Value,
	output logic [isaDefs::wordWidth-1:0] rs2Value
);
	import isaDefs::*;

	logic [wordWidth-1:0] registers [registerCount];
	logic [wordWidth-1:0] rdValue;

	// AND-OR mux, enables are one-hot
	always_comb
	begin
		rdValue = '0;
		if (rdSourceSelectLines.memoryOutputEnable)
			rdValue = rdValue | loadValue;
		if (rdSourceSelectLines.aluOutputEnable)
			rdValue = rdValue | aluResult;
		if (rdSourceSelectLines.immediateFormerOutputEnable)
			rdValue = rdValue | immediateResult;
		if (rdSourceSelectLines.branchALUOutputEnable)
			rdValue = rdValue | linkValue;
	end

	always_ff @(posedge clock)
	begin
		if (rdWriteEnable && (instruction.rd != 5'd0)) // x0 stays zero
			registers[instruction.rd] <= rdValue;
	end

	// x0 forced to zero on read
	assign rs1Value = (instruction.rs1 == 5'd0) ? '0 : registers[instruction.rs1];
	assign rs2Value = (instruction.rs2 == 5'd0) ? '0 : registers[instruction.rs2];

	assert property (@(posedge clock) rdWriteEnable |-> $onehot(rdSourceSelectLines));

endmodule

// ==== design/memoryController.sv ====
`timescale 1ns/100ps

module memoryController
(
	input logic clock,
	input logic reset,
	input controlDefs::MemoryMode_t memoryMode,
	input controlDefs::InstructionAddressSource_t instructionAddressSource,
	input logic [isaDefs::wordWidth-1:0] pc,
	input logic [isaDefs::wordWidth-1:0] nextPc,
	input logic [isaDefs::wordWidth-1:0] address,
	input logic [2:0] funct3,
	input logic [isaDefs::wordWidth-1:0] storeValue,
	input logic hostWrite,
	input logic [isaDefs::wordWidth-1:0] hostAddress,
	input logic [isaDefs::wordWidth-1:0] hostWriteData,
	output logic [isaDefs::wordWidth-1:0] instructionWord,
	output logic [isaDefs::wordWidth-1:0] loadValue,
	output logic [isaDefs::wordWidth-1:0] hostReadData,
	output logic unalignedAccess,
	output logic badFunct3
);
	import isaDefs::*;
	import controlDefs::*;

	localparam int indexWidth = $clog2(memoryWords);

	logic [wordWidth-1:0] memory [memoryWords];
	logic [wordWidth-1:0] fetchAddress;
	logic [wordWidth-1:0] dataWord; // Registered load or preload word
	logic [wordWidth-1:0] shifted, laneMask, mergedWord;
	logic [4:0] laneShift;
	logic active, isLoad;

	assign fetchAddress = (instructionAddressSource == NEXT_PC) ? nextPc : pc;
	assign laneShift = {address[1:0], 3'b000};
	assign shifted = dataWord >> laneShift;

	always_comb
	begin
		unique case (funct3)
			3'b000: loadValue = {{24{shifted[7]}}, shifted[7:0]}; // lb
			3'b001: loadValue = {{16{shifted[15]}}, shifted[15:0]}; // lh
			3'b100: loadValue = {24'b0, shifted[7:0]}; // lbu
			3'b101: loadValue = {16'b0, shifted[15:0]}; // lhu
			default: loadValue = dataWord; // lw
		endcase
	end

	// Byte lanes touched by the store
	assign laneMask = (funct3 == 3'b000) ? (32'h0000_00ff << laneShift) :
		(funct3 == 3'b001) ? (32'h0000_ffff << laneShift) : '1;
	assign mergedWord = (dataWord & ~laneMask) | ((storeValue << laneShift) & laneMask);

	always_ff @(posedge clock)
	begin
		instructionWord <= memory[fetchAddress[indexWidth+1:2]];
		if ((memoryMode == controlDefs::LOAD) || (memoryMode == STORE_PRELOAD))
			dataWord <= memory[address[indexWidth+1:2]];
		if (reset && hostWrite)
			memory[hostAddress[indexWidth+1:2]] <= hostWriteData;
		else if (memoryMode == controlDefs::STORE)
			memory[address[indexWidth+1:2]] <= mergedWord;
	end

	assign hostReadData = memory[hostAddress[indexWidth+1:2]];

	// Checks only mean something while an access is in progress
	assign active = (memoryMode != NOP);
	assign isLoad = (memoryMode == controlDefs::LOAD);
	assign unalignedAccess = active && (((funct3[1:0] == 2'b01) && address[0]) ||
		((funct3[1:0] == 2'b10) && (address[1:0] != 2'b00)));
	assign badFunct3 = active && (isLoad ? ((funct3 == 3'd3) || (funct3 >= 3'd6)) :
		(funct3 >= 3'd3));

	assert property (@(posedge clock) hostWrite |-> reset);

endmodule

// ==== design/controlLogic.sv ====
`timescale 1ns/100ps

module controlLogic
(
	input logic clock,
	input logic reset,
	input isaDefs::Instruction_t instruction,
	input logic pcMisaligned,
	input logic unalignedAccess,
	input logic badFunct3,
	output controlDefs::ControlLines_t controlLines,
	output logic halted,
	output controlDefs::HaltCause_t haltCause
);
	import isaDefs::*;
	import controlDefs::*;

	State_t state, nextState;
	logic fetchValid; // First word after reset has been registered
	logic isTwoCycle;
	logic stop, controlError, pcError, memoryError, halt;

	assign isTwoCycle = (instruction.opcode == isaDefs::LOAD) ||
		((instruction.opcode == isaDefs::STORE) && (instruction.funct3 != 3'b010)); // sb/sh merge
	assign pcError = pcMisaligned & controlLines.programCounterWriteEnable; // Only a PC that gets loaded
	assign memoryError = unalignedAccess | badFunct3; // Already gated by memory mode
	assign halt = stop | controlError | pcError | memoryError;
	assign halted = (state == HALT);

	// Wait for the first fetch to land before leaving INITIAL_FETCH
	always_ff @(posedge clock)
		fetchValid <= ~reset;

	always_ff @(negedge clock)
	begin
		if (reset)
		begin
			state <= INITIAL_FETCH;
			haltCause <= NONE;
		end
		else
		begin
			state <= nextState;
			if ((state != HALT) && halt) // Latch first cause only
			begin
				if (stop)
					haltCause <= STOP;
				else if (controlError)
					haltCause <= CONTROL_ERROR;
				else if (pcError)
					haltCause <= PC_MISALIGNED;
				else
					haltCause <= MEMORY_ERROR;
			end
		end
	end

	always_comb
	begin
		if (halt)
			nextState = HALT;
		else
		begin
			unique case (state)
				INITIAL_FETCH: nextState = !fetchValid ? INITIAL_FETCH :
					(isTwoCycle ? EXECUTE : FETCH_EXECUTE);
				FETCH_EXECUTE: nextState = isTwoCycle ? EXECUTE : FETCH_EXECUTE;
				EXECUTE: nextState = FETCH_EXECUTE; // Second half of load or sub-word store
				default: nextState = HALT; // HALT spins and a bad state stops
			endcase
		end
	end

	always_comb
	begin
		controlLines = '0; // Idle lines fetch from the current PC
		stop = 1'b0;
		controlError = 1'b0;
		if (state == FETCH_EXECUTE)
		begin
			controlLines.programCounterWriteEnable = 1'b1;
			controlLines.instructionAddressSource = NEXT_PC; // Fetch the word after this one
			controlLines.branchALUMode = INCREMENT;
			unique case (instruction.opcode)
				isaDefs::LUI, isaDefs::AUIPC:
				begin
					controlLines.rdWriteEnable = 1'b1;
					controlLines.rdSourceSelectLines.immediateFormerOutputEnable = 1'b1;
					controlLines.immediateFormerMode = (instruction.opcode == isaDefs::LUI) ?
						controlDefs::LUI : controlDefs::AUIPC;
				end
				isaDefs::JAL, isaDefs::JALR:
				begin
					controlLines.rdWriteEnable = 1'b1;
					controlLines.rdSourceSelectLines.branchALUOutputEnable = 1'b1; // Link value
					controlLines.immediateFormerMode = (instruction.opcode == isaDefs::JAL) ? J : I;
					controlLines.branchALUMode = (instruction.opcode == isaDefs::JAL) ?
						controlDefs::JAL : controlDefs::JALR;
				end
				isaDefs::BRANCH:
				begin
					controlLines.immediateFormerMode = B;
					controlLines.branchALUMode = controlDefs::BRANCH;
				end
				isaDefs::LOAD: // Second cycle after the EXECUTE read
				begin
					controlLines.rdWriteEnable = 1'b1;
					controlLines.memoryMode = controlDefs::LOAD;
					controlLines.rdSourceSelectLines.memoryOutputEnable = 1'b1;
				end
				isaDefs::STORE: // Only cycle for sw and write-back for sb/sh
				begin
					controlLines.memoryMode = controlDefs::STORE;
					controlLines.immediateFormerMode = S;
				end
				isaDefs::OP_IMM, isaDefs::OP:
				begin
					controlLines.rdWriteEnable = 1'b1;
					controlLines.rdSourceSelectLines.aluOutputEnable = 1'b1;
					controlLines.opImm = (instruction.opcode == isaDefs::OP_IMM);
				end
				isaDefs::MISC_MEM: ; // fence does nothing here
				isaDefs::SYSTEM:
				begin
					controlLines.programCounterWriteEnable = 1'b0; // Clean stop with PC held
					controlLines.instructionAddressSource = CURRENT_PC;
					stop = 1'b1;
				end
				default:
				begin
					controlLines.programCounterWriteEnable = 1'b0;
					controlError = 1'b1; // Undefined opcode
				end
			endcase
		end
		else if (state == EXECUTE)
		begin
			// Address needs the right immediate in both cycles
			controlLines.immediateFormerMode = (instruction.opcode == isaDefs::STORE) ? S : I;
			if (instruction.opcode == isaDefs::LOAD)
				controlLines.memoryMode = controlDefs::LOAD;
			else if (instruction.opcode == isaDefs::STORE)
				controlLines.memoryMode = STORE_PRELOAD;
			else
				controlError = 1'b1; // Cannot get here with a good opcode
		end
	end

	assert property (@(posedge clock) disable iff (reset) $onehot(state));
	assert property (@(posedge clock) (state == HALT) |-> !controlLines.programCounterWriteEnable);

endmodule

// ==== design/simpleCore.sv ====
`timescale 1ns/100ps

module simpleCore
(
	input logic clock,
	input logic reset,
	input logic hostWrite,
	input logic [isaDefs::wordWidth-1:0] hostAddress,
	input logic [isaDefs::wordWidth-1:0] hostWriteData,
	output logic [isaDefs::wordWidth-1:0] hostReadData,
	output logic halted,
	output controlDefs::HaltCause_t haltCause
);
	import isaDefs::*;
	import controlDefs::*;

	ControlLines_t controlLines;
	Instruction_t instruction;
	logic [wordWidth-1:0] instructionWord, pc, nextPc, linkValue;
	logic [wordWidth-1:0] rs1Value, rs2Value, aluResult, loadValue;
	logic [wordWidth-1:0] immediate, immediateResult;
	logic pcMisaligned, unalignedAccess, badFunct3;

	assign instruction = Instruction_t'(instructionWord);
	assign pcMisaligned = |nextPc[1:0];

	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= '0;
		else if (controlLines.programCounterWriteEnable)
			pc <= nextPc;
	end

	controlLogic control (.clock, .reset, .instruction, .pcMisaligned, .unalignedAccess,
		.badFunct3, .controlLines, .halted, .haltCause);

	immediateFormer immediates (.instruction, .pc,
		.immediateFormerMode(controlLines.immediateFormerMode), .immediate, .immediateResult);

	executeUnit execute (.instruction, .pc, .rs1Value, .rs2Value, .immediate,
		.opImm(controlLines.opImm), .branchALUMode(controlLines.branchALUMode),
		.aluResult, .nextPc, .linkValue);

	resultWriter results (.clock, .instruction, .rdWriteEnable(controlLines.rdWriteEnable),
		.rdSourceSelectLines(controlLines.rdSourceSelectLines), .loadValue, .aluResult,
		.immediateResult, .linkValue, .rs1Value, .rs2Value);

	memoryController memory (.clock, .reset, .memoryMode(controlLines.memoryMode),
		.instructionAddressSource(controlLines.instructionAddressSource), .pc, .nextPc,
		.address(aluResult), .funct3(instruction.funct3), .storeValue(rs2Value), .hostWrite,
		.hostAddress, .hostWriteData, .instructionWord, .loadValue, .hostReadData,
		.unalignedAccess, .badFunct3);

endmodule

// ==== dv/simpleCoreTb.sv ====
`timescale 1ns/100ps

module simpleCoreTb;
	import controlDefs::*;

	localparam int clockPeriod = 8;
	localparam int aluBound = 200; // Cycle bounds per run and in the watchdog sum
	localparam int subWordBound = 100;
	localparam int controlBound = 150;
	localparam int haltBound = 50;
	localparam int zeroBound = 50;
	localparam int resetBound = 200;
	localparam int setupCycles = 150; // Reset, host loads and readback per test
	localparam int watchdogCycles = aluBound + subWordBound + controlBound + 4 * haltBound +
		zeroBound + resetBound + 9 * setupCycles + 100;

	localparam int opcodeLoad = 7'b0000011;
	localparam int opcodeBranch = 7'b1100011;
	localparam int opcodeJalr = 7'b1100111;
	localparam int opcodeLui = 7'b0110111;
	localparam int opcodeAuipc = 7'b0010111;
	localparam int opcodeOpImm = 7'b0010011;
	localparam logic [31:0] ecallWord = 32'h0000_0073;
	localparam logic [31:0] ebreakWord = 32'h0010_0073;

	// OP table order add sub sll slt sltu xor srl sra or and
	localparam int opFunct3 [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
	localparam int opFunct7 [10] = '{0, 32, 0, 0, 0, 0, 0, 32, 0, 0};
	localparam int immOps [9] = '{0, 3, 4, 5, 8, 9, 2, 6, 7}; // OP-IMM subset of the table
	// Even entries taken and odd entries fall through with x1 = 5 and x2 = -3
	localparam int branchFunct3 [12] = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
	localparam int branchRs1 [12] = '{1, 1, 1, 1, 2, 1, 1, 2, 1, 2, 2, 1};
	localparam int branchRs2 [12] = '{1, 2, 2, 1, 1, 2, 2, 1, 2, 1, 1, 2};
	localparam int loadOffset [6] = '{0, 3, 2, 0, 2, 0};
	localparam int loadFunct3 [6] = '{0, 4, 1, 5, 0, 2}; // lb lbu lh lhu lb lw

	logic clock;
	logic reset;
	logic hostWrite;
	logic [31:0] hostAddress;
	logic [31:0] hostWriteData;
	logic [31:0] hostReadData;
	logic halted;
	HaltCause_t haltCause;
	logic [31:0] programWords [$];
	int errorCount, passCount, failCount;
	integer seed;

	simpleCore simpleCore_inst (.clock, .reset, .hostWrite, .hostAddress, .hostWriteData,
		.hostReadData, .halted, .haltCause);

	always #(clockPeriod / 2) clock = ~clock;

	function automatic logic [31:0] rType(int funct7, int funct3, int rd, int rs1, int rs2);
		return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] iType(int opcode, int funct3, int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode[6:0]};
	endfunction

	function automatic logic [31:0] sType(int funct3, int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], funct3[2:0], imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bType(int funct3, int rs1, int rs2, int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3[2:0], imm[4:1], imm[11],
			opcodeBranch[6:0]};
	endfunction

	function automatic logic [31:0] uType(int opcode, int rd, int imm);
		return {imm[19:0], rd[4:0], opcode[6:0]};
	endfunction

	function automatic logic [31:0] jType(int rd, int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	// Background for untouched words from every address bit
	function automatic logic [31:0] fillValue(logic [31:0] address);
		return ~address ^ {address[15:0], address[31:16]};
	endfunction

	// RV32I semantics for the OP table entries
	function automatic logic [31:0] aluExpected(int op, logic [31:0] a, logic [31:0] b);
		case (op)
			0: return a + b;
			1: return a - b;
			2: return a << b[4:0];
			3: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			4: return (a < b) ? 32'd1 : 32'd0;
			5: return a ^ b;
			6: return a >> b[4:0];
			7: return $signed(a) >>> b[4:0];
			8: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic stepCycle();
		@(posedge clock);
		#1;
	endtask

	task automatic compareWord(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
			errorCount++;
		end
	endtask

	task automatic compareHaltCause(input HaltCause_t actual, input HaltCause_t expected);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t haltCause: got %s, expected %s", $time, actual.name(),
				expected.name());
			errorCount++;
		end
	endtask

	task automatic holdReset();
		reset = 1'b1;
		hostWrite = 1'b0;
		programWords.delete();
		repeat (4) stepCycle();
	endtask

	task automatic writeWord(input logic [31:0] address, input logic [31:0] data);
		hostAddress = address;
		hostWriteData = data;
		hostWrite = 1'b1;
		stepCycle();
		hostWrite = 1'b0;
	endtask

	task automatic fillWords(input logic [31:0] base, input int count);
		for (int k = 0; k < count; k++)
			writeWord(base + k * 4, fillValue(base + k * 4));
	endtask

	task automatic loadConstant(input int rd, input logic [31:0] value);
		programWords.push_back(uType(opcodeLui, rd, int'((value + 32'h800) >> 12)));
		programWords.push_back(iType(opcodeOpImm, 0, rd, rd, int'(value))); // Low part sign-extends
	endtask

	// Release reset, wait for halted, check the cause, then back into reset
	task automatic runProgram(input string name, input int bound, input HaltCause_t cause);
		int cycles;
		for (int k = 0; k < programWords.size(); k++)
			writeWord(k * 4, programWords[k]);
		reset = 1'b0;
		cycles = 0;
		while (!halted && cycles < bound)
		begin
			stepCycle();
			cycles++;
		end
		if (!halted)
		begin
			$display("%s: core did not halt within %0d cycles", name, bound);
			errorCount++;
		end
		compareHaltCause(haltCause, cause);
		reset = 1'b1;
		stepCycle();
	endtask

	task automatic readCheck(input logic [31:0] address, input logic [31:0] expected);
		hostAddress = address;
		stepCycle();
		compareWord($sformatf("mem[%h]", address), hostReadData, expected);
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		if (errorCount == errorsBefore)
		begin
			passCount++;
			$display("%s: passed", name);
		end
		else
		begin
			failCount++;
			$display("%s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	task automatic aluTest();
		int errorsBefore = errorCount;
		int op, immField;
		logic [31:0] a, b, operand;
		logic [11:0] imm;
		logic [4:0] shamt;
		logic [31:0] expected [$];
		holdReset();
		a = $random(seed);
		b = $random(seed);
		imm = 12'($random(seed));
		shamt = 5'($random(seed));
		loadConstant(4, 32'h800); // Result base
		loadConstant(1, a);
		loadConstant(2, b);
		for (int k = 0; k < 10; k++)
		begin
			programWords.push_back(rType(opFunct7[k], opFunct3[k], 3, 1, 2));
			programWords.push_back(sType(2, 3, 4, k * 4));
			expected.push_back(aluExpected(k, a, b));
		end
		for (int k = 0; k < 9; k++)
		begin
			op = immOps[k];
			if (op == 2 || op == 6 || op == 7)
			begin
				immField = opFunct7[op] * 32 + int'(shamt); // srai keeps bit 30
				operand = {27'b0, shamt};
			end
			else
			begin
				immField = int'(imm);
				operand = {{20{imm[11]}}, imm};
			end
			programWords.push_back(iType(opcodeOpImm, opFunct3[op], 3, 1, immField));
			programWords.push_back(sType(2, 3, 4, 40 + k * 4));
			expected.push_back(aluExpected(op, a, operand));
		end
		programWords.push_back(ecallWord);
		fillWords(32'h800, expected.size());
		runProgram("ALU instructions", aluBound, STOP);
		for (int k = 0; k < expected.size(); k++)
			readCheck(32'h800 + k * 4, expected[k]);
		finishTest("ALU instructions", errorsBefore);
	endtask

	task automatic subWordTest();
		int errorsBefore = errorCount;
		logic [31:0] w, w2, w3;
		logic [31:0] expected [6];
		holdReset();
		w = 32'h8c7f_f281; // Bytes 81 f2 7f 8c from low address up
		w2 = 32'h1122_3344;
		w3 = 32'h5566_7788;
		loadConstant(4, 32'h900);
		for (int k = 0; k < 6; k++)
		begin
			programWords.push_back(iType(opcodeLoad, loadFunct3[k], 5, 4, loadOffset[k]));
			programWords.push_back(sType(2, 5, 4, 16 + k * 4));
		end
		programWords.push_back(iType(opcodeOpImm, 0, 6, 0, 32'ha5));
		programWords.push_back(sType(0, 6, 4, 5)); // sb into byte 1 of w2
		loadConstant(7, 32'h0000_beef);
		programWords.push_back(sType(1, 7, 4, 10)); // sh into upper half of w3
		programWords.push_back(ecallWord);
		expected = '{{{24{w[7]}}, w[7:0]}, {24'b0, w[31:24]}, {{16{w[31]}}, w[31:16]},
			{16'b0, w[15:0]}, {{24{w[23]}}, w[23:16]}, w};
		writeWord(32'h900, w);
		writeWord(32'h904, w2);
		writeWord(32'h908, w3);
		fillWords(32'h910, 6);
		runProgram("sub-word memory", subWordBound, STOP);
		for (int k = 0; k < 6; k++)
			readCheck(32'h910 + k * 4, expected[k]);
		readCheck(32'h904, {w2[31:16], 8'ha5, w2[7:0]});
		readCheck(32'h908, {16'hbeef, w3[15:0]});
		finishTest("sub-word memory", errorsBefore);
	endtask

	task automatic controlTransferTest();
		int errorsBefore = errorCount;
		int pU, pJ, pA;
		logic [31:0] expected [$];
		holdReset();
		loadConstant(4, 32'hA00);
		programWords.push_back(iType(opcodeOpImm, 0, 1, 0, 5));
		programWords.push_back(iType(opcodeOpImm, 0, 2, 0, -3));
		programWords.push_back(iType(opcodeOpImm, 0, 9, 0, 32'h5a)); // Marker
		for (int k = 0; k < 12; k++)
		begin
			programWords.push_back(bType(branchFunct3[k], branchRs1[k], branchRs2[k], 8));
			programWords.push_back(sType(2, 9, 4, k * 4)); // Skipped when taken
			expected.push_back((k % 2 == 0) ? fillValue(32'hA00 + k * 4) : 32'h5a);
		end
		pU = programWords.size() * 4;
		programWords.push_back(uType(opcodeAuipc, 13, 32'h12345));
		programWords.push_back(sType(2, 13, 4, 48));
		expected.push_back(pU + 32'h1234_5000);
		pJ = programWords.size() * 4;
		programWords.push_back(jType(11, 8));
		programWords.push_back(sType(2, 9, 4, 52));
		programWords.push_back(sType(2, 11, 4, 56));
		expected.push_back(fillValue(32'hA34));
		expected.push_back(pJ + 4);
		pA = programWords.size() * 4;
		programWords.push_back(uType(opcodeAuipc, 12, 0)); // x12 = own address
		programWords.push_back(iType(opcodeJalr, 0, 14, 12, 12));
		programWords.push_back(sType(2, 9, 4, 60));
		programWords.push_back(sType(2, 14, 4, 64));
		expected.push_back(fillValue(32'hA3C));
		expected.push_back(pA + 8); // jalr sits at pA + 4
		programWords.push_back(ecallWord);
		fillWords(32'hA00, expected.size());
		runProgram("control transfer", controlBound, STOP);
		for (int k = 0; k < expected.size(); k++)
			readCheck(32'hA00 + k * 4, expected[k]);
		finishTest("control transfer", errorsBefore);
	endtask

	// Faulting instruction followed by a store that must not land
	task automatic haltTest(input string name, input logic [31:0] faultWord,
		input HaltCause_t cause);
		int errorsBefore = errorCount;
		holdReset();
		loadConstant(4, 32'hB00);
		programWords.push_back(iType(opcodeOpImm, 0, 5, 0, 32'h77));
		programWords.push_back(faultWord);
		programWords.push_back(sType(2, 5, 4, 0));
		programWords.push_back(ecallWord);
		fillWords(32'hB00, 1);
		runProgram(name, haltBound, cause);
		readCheck(32'hB00, fillValue(32'hB00));
		finishTest(name, errorsBefore);
	endtask

	task automatic zeroRegisterTest();
		int errorsBefore = errorCount;
		holdReset();
		loadConstant(4, 32'hC00);
		programWords.push_back(iType(opcodeOpImm, 0, 0, 0, 123));
		programWords.push_back(uType(opcodeLui, 0, 32'h12345));
		programWords.push_back(sType(2, 0, 4, 0));
		programWords.push_back(ecallWord);
		fillWords(32'hC00, 1);
		runProgram("writes to x0", zeroBound, STOP);
		readCheck(32'hC00, 32'h0);
		finishTest("writes to x0", errorsBefore);
	endtask

	task automatic resetMidRunTest();
		int errorsBefore = errorCount;
		holdReset();
		programWords.push_back(iType(opcodeOpImm, 0, 1, 1, 1));
		programWords.push_back(jType(0, -4)); // Endless loop
		for (int k = 0; k < programWords.size(); k++)
			writeWord(k * 4, programWords[k]);
		reset = 1'b0;
		repeat (30) stepCycle();
		compareWord("halted", {31'b0, halted}, 32'd0);
		holdReset(); // Reset lands in the middle of the loop
		compareWord("halted", {31'b0, halted}, 32'd0);
		compareHaltCause(haltCause, NONE);
		loadConstant(4, 32'hC04);
		programWords.push_back(iType(opcodeOpImm, 0, 5, 0, 32'h2a5));
		programWords.push_back(sType(2, 5, 4, 0));
		programWords.push_back(ecallWord);
		fillWords(32'hC04, 1);
		runProgram("reset mid-run", resetBound, STOP);
		readCheck(32'hC04, 32'h2a5);
		finishTest("reset mid-run", errorsBefore);
	endtask

	initial
	begin
		#(watchdogCycles * clockPeriod);
		$display("Watchdog expired after %0d cycles, run stopped", watchdogCycles);
		$display("Test FAILED");
		$finish;
	end

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		hostWrite = 1'b0;
		hostAddress = '0;
		hostWriteData = '0;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		seed = 32'h4a40_d4e7;
		stepCycle();
		aluTest();
		subWordTest();
		controlTransferTest();
		haltTest("undefined opcode", 32'h0000_0000, CONTROL_ERROR);
		haltTest("misaligned lw", iType(opcodeLoad, 2, 6, 0, 2), MEMORY_ERROR);
		haltTest("misaligned jalr target", iType(opcodeJalr, 0, 6, 0, 6), PC_MISALIGNED);
		haltTest("ebreak", ebreakWord, STOP);
		zeroRegisterTest();
		resetMidRunTest();
		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (errorCount == 0 && failCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== simpleCore.f ====
design/isaDefs.sv
design/controlDefs.sv
design/immediateFormer.sv
design/executeUnit.sv
design/resultWriter.sv
design/memoryController.sv
design/controlLogic.sv
design/simpleCore.sv
dv/simpleCoreTb.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f simpleCore.f --top-module simpleCoreTb -Mdir obj_dir
	@out="$$(./obj_dir/VsimpleCoreTb)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

lint:
	verilator --lint-only --timing -f simpleCore.f --top-module simpleCore

clean:
	rm -rf obj_dir
